// ==== compile.f ====
logic/uart_cfg_pkg.sv
logic/uart_type_pkg.sv
logic/uart_tx_queue.sv
logic/uart_ser.sv
logic/uart_des.sv
logic/uart_top.sv
sim/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the uart testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f compile.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vuart_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== sim/uart_tb.sv ====
`timescale 1ns/1ps
//////////////////////////////
// uart testbench
// loopback and bit-banged frames checked against a byte model
//////////////////////////////

module uart_tb;

  import uart_cfg_pkg::*;
  import uart_type_pkg::*;

  logic             clk;
  logic             rst;
  logic [bdr_w-1:0] cfg_bdr;
  logic             tx_vld;
  uart_data_t       tx_dat;
  logic             tx_rdy;
  logic             txd;
  logic             rxd;
  logic             rx_vld;
  uart_data_t       rx_dat;
  logic             rx_err;

  // rxd source, loopback or bit-banged line
  logic loop;
  logic bb_line;

  // model queues and counters
  uart_data_t  sent_q[$];
  uart_data_t  got_q[$];
  int          err_strb;
  int          errors;
  int          tests;
  int          test_err;
  logic [31:0] rng;

  assign rxd = loop ? txd : bb_line;

  uart_top uut (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .tx_vld  (tx_vld),
    .tx_dat  (tx_dat),
    .tx_rdy  (tx_rdy),
    .txd     (txd),
    .rxd     (rxd),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_err  (rx_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // strobes sampled on the falling edge, away from updates
  always @(negedge clk) begin
    if (rx_vld) got_q.push_back(rx_dat);
    if (rx_err) err_strb++;
  end

  //////////////////////////////
  // model helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic uart_data_t rand_byte();
    rng = xorshift(rng);
    return rng[data_w-1:0];
  endfunction

  // start bit first on the line, stop bit last
  function automatic logic [frame_len-1:0] encode_frame(input uart_data_t b,
                                                        input logic start_lvl,
                                                        input logic stop_lvl);
    return {stop_lvl, b, start_lvl};
  endfunction

  task automatic check_byte(input string name, input uart_data_t exp, input uart_data_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_byte(input uart_data_t b);
    tx_vld = 1'b1;
    tx_dat = b;
    while (!tx_rdy) @(negedge clk);
    @(negedge clk);
    sent_q.push_back(b);
  endtask

  task automatic bit_bang(input logic [frame_len-1:0] f);
    for (int i = 0; i < frame_len; i++) begin
      bb_line = f[i];
      repeat (int'(cfg_bdr) + 1) @(negedge clk);
    end
    bb_line = 1'b1;
  endtask

  // wait for n byte strobes, or n error strobes, bounded
  task automatic wait_strobe(input logic on_err, input int n, input string name);
    int lim;
    lim = (n + 1) * frame_len * (int'(cfg_bdr) + 1);
    while (((on_err ? err_strb : got_q.size()) < n) && lim > 0) begin
      @(negedge clk);
      lim--;
    end
    if ((on_err ? err_strb : got_q.size()) < n) begin
      errors++;
      $display("%s: expected strobe never arrived", name);
    end
  endtask

  task automatic compare_all(input string name);
    while (sent_q.size() > 0 && got_q.size() > 0)
      check_byte(name, sent_q.pop_front(), got_q.pop_front());
    check_count({name, " leftover"}, 0, sent_q.size() + got_q.size());
    sent_q.delete();
    got_q.delete();
  endtask

  // two idle bits, then the line must be high
  task automatic settle();
    repeat (2 * (int'(cfg_bdr) + 1)) @(negedge clk);
    check_flag("line idle", 1'b1, txd);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int         bdr_list[3] = '{3, 10, 25};
    int         width;
    int         err0;
    uart_data_t b;
    rst = 1'b1;
    cfg_bdr = 16'd7;
    tx_vld = 1'b0;
    tx_dat = '0;
    loop = 1'b1;
    bb_line = 1'b1;
    rng = 32'h88fd470e;
    errors = 0;
    tests = 0;
    test_err = 0;
    err_strb = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    settle();

    // single byte loopback
    send_byte(rand_byte());
    tx_vld = 1'b0;
    wait_strobe(1'b0, 1, "single");
    check_flag("single rx_err", 1'b0, err_strb != 0);
    compare_all("single");
    settle();
    end_test("single");

    // burst, queue plus serializer hold five bytes
    for (int i = 0; i < 12; i++) begin
      if (i == queue_depth + 1) check_flag("burst stall", 1'b0, tx_rdy);
      else if (i < queue_depth + 1) check_flag("burst ready", 1'b1, tx_rdy);
      send_byte(rand_byte());
    end
    tx_vld = 1'b0;
    wait_strobe(1'b0, 12, "burst");
    compare_all("burst");
    settle();
    end_test("burst");

    // divider change while idle, LSB forced high to see the start bit alone
    foreach (bdr_list[k]) begin
      cfg_bdr = 16'(bdr_list[k]);
      b = rand_byte() | 8'h01;
      send_byte(b);
      tx_vld = 1'b0;
      // byte sits a cycle in the queue before txd falls
      width = 0;
      while (txd && width < frame_len) begin
        width++;
        @(negedge clk);
      end
      width = 0;
      while (!txd && width <= int'(cfg_bdr) + 2) begin
        width++;
        @(negedge clk);
      end
      check_count("start width", int'(cfg_bdr) + 1, width);
      wait_strobe(1'b0, 1, "divider");
      compare_all("divider");
      settle();
    end
    end_test("divider");

    // framing error from a low stop bit
    cfg_bdr = 16'd15;
    loop = 1'b0;
    settle();
    err0 = err_strb;
    bit_bang(encode_frame(rand_byte(), 1'b0, 1'b0));
    wait_strobe(1'b1, err0 + 1, "framing");
    check_count("framing rx_vld", 0, got_q.size());
    settle();
    b = rand_byte();
    sent_q.push_back(b);
    bit_bang(encode_frame(b, 1'b0, 1'b1));
    wait_strobe(1'b0, 1, "framing next");
    compare_all("framing next");
    settle();
    end_test("framing");

    // start glitch of two clocks, well under a quarter bit
    err0 = err_strb;
    bb_line = 1'b0;
    repeat (2) @(negedge clk);
    bb_line = 1'b1;
    // a false start would strobe within one frame
    repeat ((frame_len + 1) * (int'(cfg_bdr) + 1)) @(negedge clk);
    check_count("glitch rx_vld", 0, got_q.size());
    check_count("glitch rx_err", err0, err_strb);
    b = rand_byte();
    sent_q.push_back(b);
    bit_bang(encode_frame(b, 1'b0, 1'b1));
    wait_strobe(1'b0, 1, "glitch next");
    compare_all("glitch next");
    settle();
    end_test("glitch");

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, frames per divider plus a margin for settles and waits
  initial begin
    longint cycles;
    cycles = frame_len * ((7 + 1) * 13 + (3 + 1) + (10 + 1) + (25 + 1) + (15 + 1) * 6);
    cycles = cycles + 4000;
    #(cycles * 40);
    $display("watchdog expired, the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule : uart_tb

// ==== logic/uart_top.sv ====
`timescale 1ns/1ps
//////////////////////////////
// uart top level
// transmit queue and serializer, receive deserializer
//////////////////////////////

module uart_top (
  input  logic                           clk,
  input  logic                           rst,
  // bit period is cfg_bdr+1 clocks, change only while idle
  input  logic [uart_cfg_pkg::bdr_w-1:0] cfg_bdr,
  // host transmit port
  input  logic                           tx_vld,
  input  uart_type_pkg::uart_data_t      tx_dat,
  output logic                           tx_rdy,
  // serial lines
  output logic                           txd,
  input  logic                           rxd,
  // host receive strobes
  output logic                           rx_vld,
  output uart_type_pkg::uart_data_t      rx_dat,
  output logic                           rx_err
);

  // queue to serializer stream
  logic                      q_vld;
  uart_type_pkg::uart_data_t q_dat;
  logic                      q_rdy;

  //////////////////////////////
  // transmit lane
  //////////////////////////////

  uart_tx_queue u_queue (
    .clk    (clk),
    .rst    (rst),
    .tx_vld (tx_vld),
    .tx_dat (tx_dat),
    .tx_rdy (tx_rdy),
    .q_vld  (q_vld),
    .q_dat  (q_dat),
    .q_rdy  (q_rdy)
  );

  uart_ser u_ser (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .str_vld (q_vld),
    .str_dat (q_dat),
    .str_rdy (q_rdy),
    .txd     (txd)
  );

  //////////////////////////////
  // receive lane
  //////////////////////////////

  uart_des u_des (
    .clk     (clk),
    .rst     (rst),
    .rxd     (rxd),
    .cfg_bdr (cfg_bdr),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_err  (rx_err)
  );

endmodule : uart_top

// ==== logic/uart_des.sv ====
`timescale 1ns/1ps
//////////////////////////////
// uart deserializer
// mid-bit sampling, start and stop bit checks
//////////////////////////////

module uart_des (
  input  logic                           clk,
  input  logic                           rst,
  // serial line, asynchronous
  input  logic                           rxd,
  // bit period is cfg_bdr+1 clocks
  input  logic [uart_cfg_pkg::bdr_w-1:0] cfg_bdr,
  // received byte strobes
  output logic                           rx_vld,
  output uart_type_pkg::uart_data_t      rx_dat,
  output logic                           rx_err
);

  import uart_cfg_pkg::*;
  import uart_type_pkg::*;

  // synchronizer stages
  logic rxd_m;
  logic rxd_s;

  // receive FSM
  des_state_t des_st;

  // baud timing
  logic [bdr_w-1:0] bdr_cnt;
  logic [bdr_w-1:0] bdr_lim;
  logic             bdr_end;

  // data bit count
  logic [cnt_w-1:0] bit_cnt;
  logic             bit_end;

  // low stop bit seen, wait for line high
  logic brk;

  // incoming byte
  uart_data_t rx_shf;

  //////////////////////////////
  // synchronizer
  //////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  // half a period to reach mid start bit, then full periods
  assign bdr_lim = (des_st == des_start) ? (cfg_bdr >> 1) : cfg_bdr;
  assign bdr_end = bdr_cnt == bdr_lim;
  assign bit_end = bit_cnt == cnt_w'(data_w - 1);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      des_st  <= des_idle;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      brk     <= 1'b0;
      rx_vld  <= 1'b0;
      rx_err  <= 1'b0;
    end else begin
      // strobes last one cycle
      rx_vld  <= 1'b0;
      rx_err  <= 1'b0;
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + bdr_w'(1);
      case (des_st)
        des_idle: begin
          bdr_cnt <= '0;
          bit_cnt <= '0;
          // line only reaches idle high, so low here is a falling edge
          if (!rxd_s) des_st <= des_start;
        end
        des_start: begin
          // high at mid-bit is a glitch, drop it
          if (bdr_end) des_st <= rxd_s ? des_idle : des_data;
        end
        des_data: begin
          if (bdr_end) begin
            bit_cnt <= bit_cnt + cnt_w'(1);
            if (bit_end) des_st <= des_stop;
          end
        end
        des_stop: begin
          if (brk) begin
            // hold until the break ends
            bdr_cnt <= '0;
            if (rxd_s) begin
              brk    <= 1'b0;
              des_st <= des_idle;
            end
          end else if (bdr_end) begin
            if (rxd_s) begin
              rx_vld <= 1'b1;
              des_st <= des_idle;
            end else begin
              rx_err <= 1'b1;
              brk    <= 1'b1;
            end
          end
        end
        default: des_st <= des_idle;
      endcase
    end
  end

  // data bits in LSB first
  always_ff @(posedge clk) begin
    if ((des_st == des_data) && bdr_end) rx_shf <= {rxd_s, rx_shf[data_w-1:1]};
  end

  assign rx_dat = rx_shf;

  // good byte and framing error are exclusive
  a_strb_excl: assert property (@(posedge clk) disable iff (rst)
    !(rx_vld && rx_err));

endmodule : uart_des

// ==== logic/uart_ser.sv ====
`timescale 1ns/1ps
//////////////////////////////
// uart serializer
// 8N1 frames on txd at a runtime baud divider
//////////////////////////////

module uart_ser (
  input  logic                           clk,
  input  logic                           rst,
  // bit period is cfg_bdr+1 clocks
  input  logic [uart_cfg_pkg::bdr_w-1:0] cfg_bdr,
  // byte stream in
  input  logic                           str_vld,
  input  uart_type_pkg::uart_data_t      str_dat,
  output logic                           str_rdy,
  // serial line
  output logic                           txd
);

  import uart_cfg_pkg::*;

  // stream transfer
  logic str_trn;

  // baud timing
  logic [bdr_w-1:0] bdr_cnt;
  logic             bdr_end;

  // frame progress
  logic [cnt_w-1:0] shf_cnt;
  logic             shf_end;
  logic             shf_run;

  // byte plus start bit, LSB on the line
  logic [data_w:0]  shf_dat;

  //////////////////////////////
  // stream side
  //////////////////////////////

  assign str_trn = str_vld & str_rdy;

  // ready when idle, or in the last cycle of the stop bit
  assign str_rdy = ~shf_run | (shf_end & bdr_end);

  //////////////////////////////
  // baud counter
  //////////////////////////////

  // restarts on each transfer and at each bit end
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
    end else if (str_trn) begin
      bdr_cnt <= '0;
    end else if (shf_run) begin
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + bdr_w'(1);
    end
  end

  assign bdr_end = bdr_cnt == cfg_bdr;

  //////////////////////////////
  // bit counter and run flag
  //////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      shf_cnt <= '0;
      shf_run <= 1'b0;
    end else if (str_trn) begin
      shf_cnt <= '0;
      shf_run <= 1'b1;
    end else if (shf_run & bdr_end) begin
      if (shf_end) begin
        shf_cnt <= '0;
        shf_run <= 1'b0;
      end else begin
        shf_cnt <= shf_cnt + cnt_w'(1);
      end
    end
  end

  // last bit of the frame is the stop bit
  assign shf_end = shf_cnt == cnt_w'(frame_len - 1);

  // shifter, ones fill in behind so the stop bit and idle are high
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      shf_dat <= '1;
    end else if (str_trn) begin
      shf_dat <= {str_dat, 1'b0};
    end else if (shf_run & bdr_end) begin
      shf_dat <= {1'b1, shf_dat[data_w:1]};
    end
  end

  assign txd = shf_dat[0];

  // line idles high between frames
  a_txd_idle: assert property (@(posedge clk) disable iff (rst)
    !shf_run |-> txd);

  // bit counter never runs past the stop bit
  a_cnt_rng: assert property (@(posedge clk) disable iff (rst)
    shf_cnt < frame_len);

endmodule : uart_ser

// ==== logic/uart_tx_queue.sv ====
`timescale 1ns/1ps
//////////////////////////////
// uart transmit queue
// circular buffer between the host port and the serializer
//////////////////////////////

module uart_tx_queue (
  input  logic                      clk,
  input  logic                      rst,
  // host side
  input  logic                      tx_vld,
  input  uart_type_pkg::uart_data_t tx_dat,
  output logic                      tx_rdy,
  // serializer side
  output logic                      q_vld,
  output uart_type_pkg::uart_data_t q_dat,
  input  logic                      q_rdy
);

  import uart_cfg_pkg::*;
  import uart_type_pkg::*;

  // storage array
  uart_data_t mem [queue_depth];

  // pointers wrap on their own, depth is 2**queue_aw
  logic [queue_aw-1:0] wr_ptr;
  logic [queue_aw-1:0] rd_ptr;

  // occupancy, one bit wider to hold a full queue
  logic [queue_aw:0] occ;

  // handshakes on both sides
  logic push;
  logic pop;

  //////////////////////////////
  // handshake
  //////////////////////////////

  assign push = tx_vld & tx_rdy;
  assign pop  = q_vld & q_rdy;

  // ready while there is a free slot
  assign tx_rdy = occ != (queue_aw + 1)'(queue_depth);

  // head entry visible as soon as it is written
  assign q_vld = occ != '0;
  assign q_dat = mem[rd_ptr];

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= tx_dat;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + queue_aw'(1);
      if (pop)  rd_ptr <= rd_ptr + queue_aw'(1);
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   occ <= occ + (queue_aw + 1)'(1);
        2'b01:   occ <= occ - (queue_aw + 1)'(1);
        default: occ <= occ;
      endcase
    end
  end

  // never more entries than slots, a wrap below zero shows up as a huge count
  a_occ_max: assert property (@(posedge clk) disable iff (rst)
    occ <= queue_depth);

endmodule : uart_tx_queue

// ==== logic/uart_type_pkg.sv ====
//////////////////////////////
// uart shared types
// data byte and receive FSM states
//////////////////////////////

package uart_type_pkg;

  // one character on the line
  typedef logic [uart_cfg_pkg::data_w-1:0] uart_data_t;

  // receive FSM
  typedef enum logic [1:0] {
    des_idle,   // line high, waiting for a falling edge
    des_start,  // half-bit wait, start bit check
    des_data,   // data bits, LSB first
    des_stop    // stop sample, or waiting out a break
  } des_state_t;

endpackage : uart_type_pkg

// ==== logic/uart_cfg_pkg.sv ====
//////////////////////////////
// uart configuration constants
// frame layout, counter widths and queue size
//////////////////////////////

package uart_cfg_pkg;

  // baud divider width
  localparam int unsigned bdr_w = 16;

  // character layout, 8N1
  localparam int unsigned data_w = 8;
  localparam int unsigned stop_w = 1;

  // start + data + stop
  localparam int unsigned frame_len = 1 + data_w + stop_w;

  // bit counters, wide enough for frame_len
  localparam int unsigned cnt_w = 4;

  // transmit queue, depth must be a power of two
  localparam int unsigned queue_depth = 4;
  localparam int unsigned queue_aw = 2;

endpackage : uart_cfg_pkg
